// ==== design/host_pkg.sv ====
// Shared widths, register map, response codes and write-word views for the host domain
package host_pkg;

  localparam int unsigned CfgAddrWidth = 6;
  localparam int unsigned CfgDataWidth = 32;
  localparam int unsigned NumCounters  = 4;
  localparam int unsigned CounterWidth = 32;
  localparam int unsigned CntIdxWidth  = $clog2(NumCounters);
  localparam int unsigned SyncStages   = 2;

  // Register map, byte addresses
  localparam logic [CfgAddrWidth-1:0] CtrlAddr    = 6'h00;
  localparam logic [CfgAddrWidth-1:0] CntBaseAddr = 6'h04;
  localparam logic [CfgAddrWidth-1:0] ThrBaseAddr = 6'h14;
  localparam logic [CfgAddrWidth-1:0] ThrLastAddr = ThrBaseAddr + 6'(4 * (NumCounters - 1));

  // Returned for any address past the last threshold
  localparam logic [CfgDataWidth-1:0] UnmappedData = 32'hdeadf000;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // Control register layout
  typedef struct packed {
    logic [CfgDataWidth-2*NumCounters-3:0] rsvd;
    logic                                  fetch_en;
    logic                                  cluster_en;
    logic [NumCounters-1:0]                clear;
    logic [NumCounters-1:0]                enable;
  } ctrl_fields_t;

  // Write word, viewed by address as control or as a threshold
  typedef union packed {
    ctrl_fields_t            ctrl;
    logic [CfgDataWidth-1:0] thr;
  } cfg_wdata_u;

endpackage

// ==== design/soc_rst_gen.sv ====
// SoC reset synchronizer with a cluster reset released by the cluster enable bit
`timescale 1ns/1ns

module soc_rst_gen (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic cluster_en_i,
  output logic soc_rst_n_o,
  output logic cluster_rst_n_o
);

  logic [host_pkg::SyncStages-1:0] rst_sync_q;
  logic                            cluster_rst_q;

  // Asynchronous assert, release after SyncStages edges
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rst_sync_q <= '0;
    end else begin
      rst_sync_q <= {rst_sync_q[host_pkg::SyncStages-2:0], 1'b1};
    end
  end

  assign soc_rst_n_o = rst_sync_q[host_pkg::SyncStages-1];

  // Cluster held in reset until enabled by software
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cluster_rst_q <= 1'b0;
    end else begin
      cluster_rst_q <= soc_rst_n_o & cluster_en_i;
    end
  end

  assign cluster_rst_n_o = cluster_rst_q;

  // Cluster must never leave reset ahead of the SoC
  a_cluster_after_soc : assert property (
    @(posedge clk_i) !soc_rst_n_o |-> !cluster_rst_n_o
  ) else $error("cluster reset released while SoC reset is active");

endmodule

// ==== design/edge_propagator_rx.sv ====
// Receives a toggle-encoded event from another clock domain and returns it as a one-cycle pulse
`timescale 1ns/1ns

module edge_propagator_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic valid_o
);

  logic [host_pkg::SyncStages-1:0] sync_q;
  logic                            edge_q;
  logic                            pulse_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q  <= '0;
      edge_q  <= 1'b0;
      pulse_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[host_pkg::SyncStages-2:0], valid_i};
      edge_q  <= sync_q[host_pkg::SyncStages-1];
      // Any change of the synchronized level is one event
      pulse_q <= sync_q[host_pkg::SyncStages-1] ^ edge_q;
    end
  end

  // Sender sees its own level come back once synchronized
  assign ack_o   = sync_q[host_pkg::SyncStages-1];
  assign valid_o = pulse_q;

  // Sender waits for ack before toggling again, so pulses never merge
  a_single_pulse : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o |=> !valid_o
  ) else $error("DMA event pulse lasted more than one cycle");

endmodule

// ==== design/pmu_counters.sv ====
// Event counters for the LLC strobes with saturation, clear and threshold interrupts
`timescale 1ns/1ns

module pmu_counters (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic [host_pkg::NumCounters-1:0]                      event_i,
  input  logic [host_pkg::NumCounters-1:0]                      enable_i,
  input  logic [host_pkg::NumCounters-1:0]                      clear_i,
  input  logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] threshold_i,
  output logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] cnt_o,
  output logic [host_pkg::NumCounters-1:0]                      irq_o
);

  logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] cnt_q;
  logic [host_pkg::NumCounters-1:0]                             cnt_sat;
  logic [host_pkg::NumCounters-1:0]                             cnt_inc;

  always_comb begin
    for (int i = 0; i < host_pkg::NumCounters; i++) begin
      cnt_sat[i] = &cnt_q[i];
      // Stop at all ones instead of wrapping
      cnt_inc[i] = event_i[i] & enable_i[i] & ~cnt_sat[i];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < host_pkg::NumCounters; i++) begin
        // Clear wins over a same-cycle event
        if (clear_i[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_inc[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign cnt_o = cnt_q;

  // Level interrupt, a zero threshold disables it
  always_comb begin
    for (int i = 0; i < host_pkg::NumCounters; i++) begin
      irq_o[i] = (threshold_i[i] != '0) && (cnt_q[i] >= threshold_i[i]);
    end
  end

  for (genvar g = 0; g < host_pkg::NumCounters; g++) begin : gen_irq_chk
    a_irq_needs_thr : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      irq_o[g] |-> (threshold_i[g] != '0)
    ) else $error("interrupt %0d raised with a zero threshold", g);
  end

endmodule

// ==== design/host_cfg_regs.sv ====
// Lite-style config slave holding PMU control, thresholds and counter readback
`timescale 1ns/1ns

module host_cfg_regs (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  logic                                                  cfg_wr_valid_i,
  output logic                                                  cfg_wr_ready_o,
  input  logic [host_pkg::CfgAddrWidth-1:0]                     cfg_wr_addr_i,
  input  logic [host_pkg::CfgDataWidth-1:0]                     cfg_wr_data_i,
  output logic                                                  cfg_b_valid_o,
  input  logic                                                  cfg_b_ready_i,
  output logic [1:0]                                            cfg_b_resp_o,
  input  logic                                                  cfg_rd_valid_i,
  output logic                                                  cfg_rd_ready_o,
  input  logic [host_pkg::CfgAddrWidth-1:0]                     cfg_rd_addr_i,
  output logic                                                  cfg_r_valid_o,
  input  logic                                                  cfg_r_ready_i,
  output logic [host_pkg::CfgDataWidth-1:0]                     cfg_r_data_o,
  output logic [1:0]                                            cfg_r_resp_o,
  input  logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] cnt_i,
  output logic [host_pkg::NumCounters-1:0]                      enable_o,
  output logic [host_pkg::NumCounters-1:0]                      clear_o,
  output logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] threshold_o,
  output logic                                                  cluster_en_o,
  output logic                                                  fetch_en_o
);

  host_pkg::cfg_wdata_u                    wr_word;
  host_pkg::ctrl_fields_t                  rd_ctrl;
  logic [host_pkg::CfgAddrWidth-1:0]       wr_addr;
  logic [host_pkg::CfgAddrWidth-1:0]       rd_addr;
  logic [host_pkg::CntIdxWidth-1:0]        wr_idx;
  logic [host_pkg::CntIdxWidth-1:0]        cnt_idx;
  logic [host_pkg::CntIdxWidth-1:0]        thr_idx;
  logic                                    wr_hs;
  logic                                    rd_hs;
  logic [host_pkg::CfgDataWidth-1:0]       rd_data;
  logic [1:0]                              rd_resp;
  logic [host_pkg::NumCounters-1:0]        enable_q;
  logic                                    cluster_en_q;
  logic                                    fetch_en_q;
  logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] thr_q;
  logic                                    b_valid_q;
  logic                                    r_valid_q;
  logic [1:0]                              b_resp_q;
  logic [1:0]                              r_resp_q;
  logic [host_pkg::CfgDataWidth-1:0]       r_data_q;

  // Slot index inside a counter or threshold block
  function automatic logic [host_pkg::CntIdxWidth-1:0] slot_idx(
    input logic [host_pkg::CfgAddrWidth-1:0] addr,
    input logic [host_pkg::CfgAddrWidth-1:0] base
  );
    logic [host_pkg::CfgAddrWidth-1:0] offs;
    offs = addr - base;
    return offs[host_pkg::CntIdxWidth+1:2];
  endfunction

  // Byte lanes are ignored
  assign wr_addr = {cfg_wr_addr_i[host_pkg::CfgAddrWidth-1:2], 2'b00};
  assign rd_addr = {cfg_rd_addr_i[host_pkg::CfgAddrWidth-1:2], 2'b00};
  assign wr_word = cfg_wr_data_i;
  assign wr_idx  = slot_idx(wr_addr, host_pkg::ThrBaseAddr);
  assign cnt_idx = slot_idx(rd_addr, host_pkg::CntBaseAddr);
  assign thr_idx = slot_idx(rd_addr, host_pkg::ThrBaseAddr);

  assign cfg_wr_ready_o = ~b_valid_q;
  assign cfg_rd_ready_o = ~r_valid_q;
  assign wr_hs = cfg_wr_valid_i & cfg_wr_ready_o;
  assign rd_hs = cfg_rd_valid_i & cfg_rd_ready_o;

  // Clear acts at the write edge only
  assign clear_o = (wr_hs && wr_addr == host_pkg::CtrlAddr) ? wr_word.ctrl.clear : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q     <= '0;
      cluster_en_q <= 1'b0;
      fetch_en_q   <= 1'b0;
      thr_q        <= '0;
    end else if (wr_hs) begin
      if (wr_addr == host_pkg::CtrlAddr) begin
        enable_q     <= wr_word.ctrl.enable;
        cluster_en_q <= wr_word.ctrl.cluster_en;
        fetch_en_q   <= wr_word.ctrl.fetch_en;
      end else if (wr_addr >= host_pkg::ThrBaseAddr && wr_addr <= host_pkg::ThrLastAddr) begin
        thr_q[wr_idx] <= wr_word.thr;
      end
    end
  end

  always_comb begin
    rd_ctrl            = '0;
    rd_ctrl.enable     = enable_q;
    rd_ctrl.cluster_en = cluster_en_q;
    rd_ctrl.fetch_en   = fetch_en_q;
    rd_data            = host_pkg::UnmappedData;
    rd_resp            = host_pkg::RespSlvErr;
    if (rd_addr == host_pkg::CtrlAddr) begin
      rd_data = rd_ctrl;
      rd_resp = host_pkg::RespOkay;
    end else if (rd_addr < host_pkg::ThrBaseAddr) begin
      rd_data = cnt_i[cnt_idx];
      rd_resp = host_pkg::RespOkay;
    end else if (rd_addr <= host_pkg::ThrLastAddr) begin
      rd_data = thr_q[thr_idx];
      rd_resp = host_pkg::RespOkay;
    end
  end

  // Response handshakes
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (wr_hs) begin
        b_valid_q <= 1'b1;
      end else if (cfg_b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (cfg_r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_resp_q <= host_pkg::RespOkay;
      r_data_q <= '0;
      r_resp_q <= host_pkg::RespOkay;
    end else begin
      if (wr_hs) begin
        b_resp_q <= (wr_addr > host_pkg::ThrLastAddr) ?
                    host_pkg::RespSlvErr : host_pkg::RespOkay;
      end
      if (rd_hs) begin
        r_data_q <= rd_data;
        r_resp_q <= rd_resp;
      end
    end
  end

  assign cfg_b_valid_o = b_valid_q;
  assign cfg_b_resp_o  = b_resp_q;
  assign cfg_r_valid_o = r_valid_q;
  assign cfg_r_data_o  = r_data_q;
  assign cfg_r_resp_o  = r_resp_q;
  assign enable_o      = enable_q;
  assign threshold_o   = thr_q;
  assign cluster_en_o  = cluster_en_q;
  assign fetch_en_o    = fetch_en_q;

  a_b_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_b_valid_o && !cfg_b_ready_i |=> cfg_b_valid_o && $stable(cfg_b_resp_o)
  ) else $error("write response dropped before b_ready");

  a_one_write : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_b_valid_o |-> !wr_hs
  ) else $error("write accepted while a response is pending");

endmodule

// ==== design/host_domain.sv ====
// Host domain top level, ties reset generation, DMA event receiver, config slave and PMU
`timescale 1ns/1ns

module host_domain (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Cluster DMA event toggle
  input  logic                             dma_pe_evt_valid_i,
  output logic                             dma_pe_evt_ack_o,
  output logic                             dma_pe_evt_o,
  // LLC event strobes
  input  logic                             llc_read_hit_i,
  input  logic                             llc_read_miss_i,
  input  logic                             llc_write_hit_i,
  input  logic                             llc_write_miss_i,
  // Config write channel
  input  logic                             cfg_wr_valid_i,
  output logic                             cfg_wr_ready_o,
  input  logic [host_pkg::CfgAddrWidth-1:0] cfg_wr_addr_i,
  input  logic [host_pkg::CfgDataWidth-1:0] cfg_wr_data_i,
  output logic                             cfg_b_valid_o,
  input  logic                             cfg_b_ready_i,
  output logic [1:0]                       cfg_b_resp_o,
  // Config read channel
  input  logic                             cfg_rd_valid_i,
  output logic                             cfg_rd_ready_o,
  input  logic [host_pkg::CfgAddrWidth-1:0] cfg_rd_addr_i,
  output logic                             cfg_r_valid_o,
  input  logic                             cfg_r_ready_i,
  output logic [host_pkg::CfgDataWidth-1:0] cfg_r_data_o,
  output logic [1:0]                       cfg_r_resp_o,
  // Resets and cluster control
  output logic                             soc_rst_n_o,
  output logic                             cluster_rst_n_o,
  output logic                             cluster_fetch_en_o,
  output logic [host_pkg::NumCounters-1:0]  pmu_irq_o
);

  logic                                                      cluster_en;
  logic [host_pkg::NumCounters-1:0]                          llc_events;
  logic [host_pkg::NumCounters-1:0]                          cnt_enable;
  logic [host_pkg::NumCounters-1:0]                          cnt_clear;
  logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] cnt_value;
  logic [host_pkg::NumCounters-1:0][host_pkg::CounterWidth-1:0] cnt_threshold;

  // Counter order is read hit, read miss, write hit, write miss
  assign llc_events = {llc_write_miss_i, llc_write_hit_i, llc_read_miss_i, llc_read_hit_i};

  soc_rst_gen i_soc_rst_gen (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .cluster_en_i    ( cluster_en      ),
    .soc_rst_n_o     ( soc_rst_n_o     ),
    .cluster_rst_n_o ( cluster_rst_n_o )
  );

  edge_propagator_rx i_edge_propagator_rx (
    .clk_i   ( clk_i              ),
    .rst_n_i ( soc_rst_n_o        ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .valid_o ( dma_pe_evt_o       )
  );

  host_cfg_regs i_host_cfg_regs (
    .clk_i          ( clk_i              ),
    .rst_n_i        ( soc_rst_n_o        ),
    .cfg_wr_valid_i ( cfg_wr_valid_i     ),
    .cfg_wr_ready_o ( cfg_wr_ready_o     ),
    .cfg_wr_addr_i  ( cfg_wr_addr_i      ),
    .cfg_wr_data_i  ( cfg_wr_data_i      ),
    .cfg_b_valid_o  ( cfg_b_valid_o      ),
    .cfg_b_ready_i  ( cfg_b_ready_i      ),
    .cfg_b_resp_o   ( cfg_b_resp_o       ),
    .cfg_rd_valid_i ( cfg_rd_valid_i     ),
    .cfg_rd_ready_o ( cfg_rd_ready_o     ),
    .cfg_rd_addr_i  ( cfg_rd_addr_i      ),
    .cfg_r_valid_o  ( cfg_r_valid_o      ),
    .cfg_r_ready_i  ( cfg_r_ready_i      ),
    .cfg_r_data_o   ( cfg_r_data_o       ),
    .cfg_r_resp_o   ( cfg_r_resp_o       ),
    .cnt_i          ( cnt_value          ),
    .enable_o       ( cnt_enable         ),
    .clear_o        ( cnt_clear          ),
    .threshold_o    ( cnt_threshold      ),
    .cluster_en_o   ( cluster_en         ),
    .fetch_en_o     ( cluster_fetch_en_o )
  );

  pmu_counters i_pmu_counters (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( soc_rst_n_o   ),
    .event_i     ( llc_events    ),
    .enable_i    ( cnt_enable    ),
    .clear_i     ( cnt_clear     ),
    .threshold_i ( cnt_threshold ),
    .cnt_o       ( cnt_value     ),
    .irq_o       ( pmu_irq_o     )
  );

endmodule

// ==== dv/host_checker.sv ====
// Reference model of the host domain that watches the DUT ports and counts mismatches
`timescale 1ns/1ns

module host_checker (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  string       test_name_i,
  input  logic        soc_rst_n_i,
  input  logic        cluster_rst_n_i,
  input  logic        fetch_en_i,
  input  logic        dma_valid_i,
  input  logic        dma_ack_i,
  input  logic        dma_evt_i,
  input  logic [3:0]  llc_evt_i,
  input  logic        wr_valid_i,
  input  logic        wr_ready_i,
  input  logic [5:0]  wr_addr_i,
  input  logic [31:0] wr_data_i,
  input  logic        b_valid_i,
  input  logic        b_ready_i,
  input  logic [1:0]  b_resp_i,
  input  logic        rd_valid_i,
  input  logic        rd_ready_i,
  input  logic [5:0]  rd_addr_i,
  input  logic        r_valid_i,
  input  logic        r_ready_i,
  input  logic [31:0] r_data_i,
  input  logic [1:0]  r_resp_i,
  input  logic [3:0]  irq_i,
  output int          check_cnt_o,
  output int          error_cnt_o
);

  logic [31:0] cnt_m [4];
  logic [31:0] thr_m [4];
  logic [3:0]  en_m;
  logic        cl_en_m;
  logic        fe_m;
  logic        cl_rst_m;
  logic        b_pend;
  logic        r_pend;
  logic [1:0]  exp_b_resp;
  logic [1:0]  exp_r_resp;
  logic [31:0] exp_r_data;
  logic        sync_m1;
  logic        sync_m2;
  logic        ack_m1;
  logic        ack_m2;
  int          rst_edges = 0;
  int          checks = 0;
  int          errors = 0;

  assign check_cnt_o = checks;
  assign error_cnt_o = errors;

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: %s expected %h actual %h", test_name_i, what, exp, act);
    end
  endtask

  // Register map: control, four counters, four thresholds, then filler with SLVERR
  task automatic reg_read(input logic [5:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    logic [5:0] a;
    logic [5:0] offs;
    a    = {addr[5:2], 2'b00};
    resp = 2'd0;
    if (a == 6'h00) begin
      data = {22'd0, fe_m, cl_en_m, 4'd0, en_m};
    end else if (a < 6'h14) begin
      offs = a - 6'h04;
      data = cnt_m[offs[3:2]];
    end else if (a <= 6'h20) begin
      offs = a - 6'h14;
      data = thr_m[offs[3:2]];
    end else begin
      data = 32'hdeadf000;
      resp = 2'd2;
    end
  endtask

  task automatic reset_model();
    for (int i = 0; i < 4; i++) begin
      cnt_m[i] = '0;
      thr_m[i] = '0;
    end
    en_m     = '0;
    cl_en_m  = 1'b0;
    fe_m     = 1'b0;
    cl_rst_m = 1'b0;
    b_pend   = 1'b0;
    r_pend   = 1'b0;
    sync_m1  = 1'b0;
    sync_m2  = 1'b0;
    ack_m1   = 1'b0;
    ack_m2   = 1'b0;
  endtask

  task automatic compare_outputs();
    logic [3:0] exp_irq;
    check_val("cfg_b_valid_o", 32'(b_pend), 32'(b_valid_i));
    check_val("cfg_wr_ready_o", 32'(!b_pend), 32'(wr_ready_i));
    check_val("cfg_r_valid_o", 32'(r_pend), 32'(r_valid_i));
    check_val("cfg_rd_ready_o", 32'(!r_pend), 32'(rd_ready_i));
    if (b_pend) begin
      check_val("cfg_b_resp_o", 32'(exp_b_resp), 32'(b_resp_i));
    end
    if (r_pend) begin
      check_val("cfg_r_data_o", exp_r_data, r_data_i);
      check_val("cfg_r_resp_o", 32'(exp_r_resp), 32'(r_resp_i));
    end
    // Level interrupt, never with a zero threshold
    for (int i = 0; i < 4; i++) begin
      exp_irq[i] = (thr_m[i] != 0) && (cnt_m[i] >= thr_m[i]);
    end
    check_val("pmu_irq_o", 32'(exp_irq), 32'(irq_i));
    check_val("cluster_rst_n_o", 32'(cl_rst_m), 32'(cluster_rst_n_i));
    check_val("cluster_fetch_en_o", 32'(fe_m), 32'(fetch_en_i));
    check_val("dma_pe_evt_ack_o", 32'(sync_m2), 32'(dma_ack_i));
    check_val("dma_pe_evt_o", 32'(ack_m1 != ack_m2), 32'(dma_evt_i));
  endtask

  task automatic update_model();
    logic [3:0] clr;
    logic [5:0] wa;
    logic [5:0] offs;
    logic       wr_hs;
    ack_m2   = ack_m1;
    ack_m1   = sync_m2;
    sync_m2  = sync_m1;
    sync_m1  = dma_valid_i;
    cl_rst_m = cl_en_m;
    // Read data is taken before this edge changes any counter
    if (rd_valid_i && !r_pend) begin
      reg_read(rd_addr_i, exp_r_data, exp_r_resp);
      r_pend = 1'b1;
    end else if (r_ready_i) begin
      r_pend = 1'b0;
    end
    wa    = {wr_addr_i[5:2], 2'b00};
    wr_hs = wr_valid_i && !b_pend;
    clr   = (wr_hs && wa == 6'h00) ? wr_data_i[7:4] : 4'd0;
    for (int i = 0; i < 4; i++) begin
      if (clr[i]) begin
        cnt_m[i] = '0;
      end else if (llc_evt_i[i] && en_m[i] && cnt_m[i] != 32'hffff_ffff) begin
        cnt_m[i] = cnt_m[i] + 32'd1;
      end
    end
    if (wr_hs) begin
      exp_b_resp = (wa > 6'h20) ? 2'd2 : 2'd0;
      b_pend     = 1'b1;
      if (wa == 6'h00) begin
        en_m    = wr_data_i[3:0];
        cl_en_m = wr_data_i[8];
        fe_m    = wr_data_i[9];
      end else if (wa >= 6'h14 && wa <= 6'h20) begin
        offs = wa - 6'h14;
        thr_m[offs[3:2]] = wr_data_i;
      end
    end else if (b_ready_i) begin
      b_pend = 1'b0;
    end
  endtask

  // Samples pre-edge values, DUT flops update later in the same step
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_edges = 0;
    end
    check_val("soc_rst_n_o", 32'(rst_edges >= 2), 32'(soc_rst_n_i));
    if (rst_n_i && rst_edges < 2) begin
      rst_edges++;
    end
    if (!soc_rst_n_i) begin
      reset_model();
    end
    compare_outputs();
    if (soc_rst_n_i) begin
      update_model();
    end
  end

endmodule

// ==== dv/tb_host_domain.sv ====
// Testbench for the host domain, applies a table of config accesses, bursts and DMA toggles
`timescale 1ns/1ns

module tb_host_domain;

  localparam int drive_dly  = 10;
  localparam int wait_limit = 50;
  localparam int op_write   = 0;
  localparam int op_read    = 1;
  localparam int op_burst   = 2;
  localparam int op_dma     = 3;

  logic        clk_i;
  logic        rst_n_i;
  logic        dma_pe_evt_valid_i;
  logic        dma_pe_evt_ack_o;
  logic        dma_pe_evt_o;
  logic        llc_read_hit_i;
  logic        llc_read_miss_i;
  logic        llc_write_hit_i;
  logic        llc_write_miss_i;
  logic        cfg_wr_valid_i;
  logic        cfg_wr_ready_o;
  logic [5:0]  cfg_wr_addr_i;
  logic [31:0] cfg_wr_data_i;
  logic        cfg_b_valid_o;
  logic        cfg_b_ready_i;
  logic [1:0]  cfg_b_resp_o;
  logic        cfg_rd_valid_i;
  logic        cfg_rd_ready_o;
  logic [5:0]  cfg_rd_addr_i;
  logic        cfg_r_valid_o;
  logic        cfg_r_ready_i;
  logic [31:0] cfg_r_data_o;
  logic [1:0]  cfg_r_resp_o;
  logic        soc_rst_n_o;
  logic        cluster_rst_n_o;
  logic        cluster_fetch_en_o;
  logic [3:0]  pmu_irq_o;

  string       test_name;
  logic [31:0] lcg_state;
  int          timeouts;
  int          check_cnt;
  int          error_cnt;

  // Stimulus table
  string       step_name [$];
  int          step_op [$];
  logic [5:0]  step_addr [$];
  logic [31:0] step_data [$];
  int          step_cyc [$];

  host_domain i_dut (
    .clk_i              ( clk_i              ),
    .rst_n_i            ( rst_n_i            ),
    .dma_pe_evt_valid_i ( dma_pe_evt_valid_i ),
    .dma_pe_evt_ack_o   ( dma_pe_evt_ack_o   ),
    .dma_pe_evt_o       ( dma_pe_evt_o       ),
    .llc_read_hit_i     ( llc_read_hit_i     ),
    .llc_read_miss_i    ( llc_read_miss_i    ),
    .llc_write_hit_i    ( llc_write_hit_i    ),
    .llc_write_miss_i   ( llc_write_miss_i   ),
    .cfg_wr_valid_i     ( cfg_wr_valid_i     ),
    .cfg_wr_ready_o     ( cfg_wr_ready_o     ),
    .cfg_wr_addr_i      ( cfg_wr_addr_i      ),
    .cfg_wr_data_i      ( cfg_wr_data_i      ),
    .cfg_b_valid_o      ( cfg_b_valid_o      ),
    .cfg_b_ready_i      ( cfg_b_ready_i      ),
    .cfg_b_resp_o       ( cfg_b_resp_o       ),
    .cfg_rd_valid_i     ( cfg_rd_valid_i     ),
    .cfg_rd_ready_o     ( cfg_rd_ready_o     ),
    .cfg_rd_addr_i      ( cfg_rd_addr_i      ),
    .cfg_r_valid_o      ( cfg_r_valid_o      ),
    .cfg_r_ready_i      ( cfg_r_ready_i      ),
    .cfg_r_data_o       ( cfg_r_data_o       ),
    .cfg_r_resp_o       ( cfg_r_resp_o       ),
    .soc_rst_n_o        ( soc_rst_n_o        ),
    .cluster_rst_n_o    ( cluster_rst_n_o    ),
    .cluster_fetch_en_o ( cluster_fetch_en_o ),
    .pmu_irq_o          ( pmu_irq_o          )
  );

  host_checker i_checker (
    .clk_i           ( clk_i              ),
    .rst_n_i         ( rst_n_i            ),
    .test_name_i     ( test_name          ),
    .soc_rst_n_i     ( soc_rst_n_o        ),
    .cluster_rst_n_i ( cluster_rst_n_o    ),
    .fetch_en_i      ( cluster_fetch_en_o ),
    .dma_valid_i     ( dma_pe_evt_valid_i ),
    .dma_ack_i       ( dma_pe_evt_ack_o   ),
    .dma_evt_i       ( dma_pe_evt_o       ),
    .llc_evt_i       ( {llc_write_miss_i, llc_write_hit_i, llc_read_miss_i, llc_read_hit_i} ),
    .wr_valid_i      ( cfg_wr_valid_i     ),
    .wr_ready_i      ( cfg_wr_ready_o     ),
    .wr_addr_i       ( cfg_wr_addr_i      ),
    .wr_data_i       ( cfg_wr_data_i      ),
    .b_valid_i       ( cfg_b_valid_o      ),
    .b_ready_i       ( cfg_b_ready_i      ),
    .b_resp_i        ( cfg_b_resp_o       ),
    .rd_valid_i      ( cfg_rd_valid_i     ),
    .rd_ready_i      ( cfg_rd_ready_o     ),
    .rd_addr_i       ( cfg_rd_addr_i      ),
    .r_valid_i       ( cfg_r_valid_o      ),
    .r_ready_i       ( cfg_r_ready_i      ),
    .r_data_i        ( cfg_r_data_o       ),
    .r_resp_i        ( cfg_r_resp_o       ),
    .irq_i           ( pmu_irq_o          ),
    .check_cnt_o     ( check_cnt          ),
    .error_cnt_o     ( error_cnt          )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #drive_dly;
  endtask

  task automatic add_step(input string name, input int op, input logic [5:0] addr,
                          input logic [31:0] data, input int cyc);
    step_name.push_back(name);
    step_op.push_back(op);
    step_addr.push_back(addr);
    step_data.push_back(data);
    step_cyc.push_back(cyc);
  endtask

  // Bounded wait on one named condition, checked at the drive point
  task automatic wait_until(input int which, input string what);
    int t;
    t = 0;
    while (!cond_met(which) && t < wait_limit) begin
      next_cycle();
      t++;
    end
    if (!cond_met(which)) begin
      timeouts++;
      $display("ERROR: test %s timed out waiting for %s", test_name, what);
    end
  endtask

  function automatic logic cond_met(input int which);
    case (which)
      0: return cfg_wr_ready_o;
      1: return cfg_b_valid_o;
      2: return cfg_rd_ready_o;
      3: return cfg_r_valid_o;
      4: return dma_pe_evt_ack_o == dma_pe_evt_valid_i;
      default: return soc_rst_n_o;
    endcase
  endfunction

  // One request, then the response is held back for hold cycles
  task automatic do_access(input logic is_wr, input logic [5:0] addr,
                           input logic [31:0] data, input int hold);
    if (is_wr) begin
      cfg_wr_valid_i = 1'b1;
      cfg_wr_addr_i  = addr;
      cfg_wr_data_i  = data;
    end else begin
      cfg_rd_valid_i = 1'b1;
      cfg_rd_addr_i  = addr;
    end
    wait_until(is_wr ? 0 : 2, is_wr ? "write ready" : "read ready");
    next_cycle();
    cfg_wr_valid_i = 1'b0;
    cfg_rd_valid_i = 1'b0;
    wait_until(is_wr ? 1 : 3, is_wr ? "write response" : "read response");
    repeat (hold) next_cycle();
    cfg_b_ready_i = is_wr;
    cfg_r_ready_i = !is_wr;
    next_cycle();
    cfg_b_ready_i = 1'b0;
    cfg_r_ready_i = 1'b0;
  endtask

  task automatic run_burst(input int cycles);
    repeat (cycles) begin
      lcg_state = lcg_next(lcg_state);
      {llc_write_miss_i, llc_write_hit_i, llc_read_miss_i, llc_read_hit_i} = lcg_state[31:28];
      next_cycle();
    end
    {llc_write_miss_i, llc_write_hit_i, llc_read_miss_i, llc_read_hit_i} = 4'b0000;
  endtask

  task automatic toggle_dma(input int settle);
    dma_pe_evt_valid_i = !dma_pe_evt_valid_i;
    wait_until(4, "DMA acknowledge");
    repeat (settle) next_cycle();
  endtask

  task automatic build_table();
    add_step("rst_ctrl_rd", op_read, 6'h00, 0, 0);
    add_step("rst_cnt2_rd", op_read, 6'h0c, 0, 0);
    add_step("rst_thr3_rd", op_read, 6'h20, 0, 0);
    add_step("cluster_on", op_write, 6'h00, 32'h0000_0300, 0);
    add_step("cluster_rd", op_read, 6'h00, 0, 0);
    add_step("fetch_off", op_write, 6'h00, 32'h0000_0100, 2);
    add_step("cluster_off", op_write, 6'h00, 32'h0000_0000, 0);
    add_step("thr0_wr", op_write, 6'h14, 32'h0000_0010, 0);
    add_step("thr1_wr", op_write, 6'h18, 32'h0000_0008, 0);
    add_step("thr2_wr", op_write, 6'h1c, 32'h0000_0040, 0);
    add_step("thr0_rd", op_read, 6'h14, 0, 0);
    add_step("thr1_rd", op_read, 6'h18, 0, 0);
    add_step("thr2_rd", op_read, 6'h1c, 0, 0);
    add_step("unmapped_rd", op_read, 6'h24, 0, 0);
    add_step("unmapped_top_rd", op_read, 6'h3c, 0, 0);
    add_step("unmapped_wr", op_write, 6'h28, 32'h5a5a_5a5a, 0);
    add_step("cnt_wr_ignored", op_write, 6'h04, 32'h0000_1234, 0);
    add_step("cnt_wr_rd", op_read, 6'h04, 0, 0);
    add_step("enable_all", op_write, 6'h00, 32'h0000_000f, 0);
    add_step("burst_all", op_burst, 6'h00, 0, 40);
    add_step("cnt0_rd", op_read, 6'h04, 0, 0);
    add_step("cnt1_rd", op_read, 6'h08, 0, 0);
    add_step("cnt2_rd", op_read, 6'h0c, 0, 0);
    add_step("cnt3_rd", op_read, 6'h10, 0, 0);
    add_step("enable_odd", op_write, 6'h00, 32'h0000_000a, 0);
    add_step("burst_odd", op_burst, 6'h00, 0, 30);
    add_step("cnt0_hold_rd", op_read, 6'h04, 0, 0);
    add_step("clear_low", op_write, 6'h00, 32'h0000_003a, 0);
    add_step("cnt0_clr_rd", op_read, 6'h04, 0, 0);
    add_step("cnt1_clr_rd", op_read, 6'h08, 0, 0);
    add_step("cnt3_kept_rd", op_read, 6'h10, 0, 0);
    add_step("thr1_zero", op_write, 6'h18, 32'h0000_0000, 0);
    add_step("burst_thr_zero", op_burst, 6'h00, 0, 20);
    add_step("dma_rise", op_dma, 6'h00, 0, 4);
    add_step("dma_fall", op_dma, 6'h00, 0, 4);
    add_step("dma_rise_again", op_dma, 6'h00, 0, 4);
    add_step("b_backpressure", op_write, 6'h1c, 32'h0000_0003, 6);
    add_step("r_backpressure", op_read, 6'h1c, 0, 6);
  endtask

  initial begin
    rst_n_i            = 1'b0;
    dma_pe_evt_valid_i = 1'b0;
    {llc_write_miss_i, llc_write_hit_i, llc_read_miss_i, llc_read_hit_i} = 4'b0000;
    cfg_wr_valid_i     = 1'b0;
    cfg_wr_addr_i      = '0;
    cfg_wr_data_i      = '0;
    cfg_b_ready_i      = 1'b0;
    cfg_rd_valid_i     = 1'b0;
    cfg_rd_addr_i      = '0;
    cfg_r_ready_i      = 1'b0;
    lcg_state          = 32'h1c3c_3d07;
    timeouts           = 0;
    test_name          = "reset";
    build_table();
    repeat (5) @(posedge clk_i);
    #drive_dly;
    rst_n_i = 1'b1;
    wait_until(5, "SoC reset release");
    for (int i = 0; i < step_op.size(); i++) begin
      test_name = step_name[i];
      case (step_op[i])
        op_write: do_access(1'b1, step_addr[i], step_data[i], step_cyc[i]);
        op_read:  do_access(1'b0, step_addr[i], step_data[i], step_cyc[i]);
        op_burst: run_burst(step_cyc[i]);
        default:  toggle_dma(step_cyc[i]);
      endcase
    end
    repeat (4) next_cycle();
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d", check_cnt, error_cnt, timeouts);
    if (error_cnt == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
design/host_pkg.sv
design/soc_rst_gen.sv
design/edge_propagator_rx.sv
design/pmu_counters.sv
design/host_cfg_regs.sv
design/host_domain.sv
dv/host_checker.sv
dv/tb_host_domain.sv

// ==== Makefile ====
TOOL      = verilator
TOP       = tb_host_domain
FILE_LIST = verilog.f
FLAGS     = --timing --assert -Wno-fatal
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
